// ==== parse_consts.svh ====
`ifndef PARSE_CONSTS_SVH
`define PARSE_CONSTS_SVH
`default_nettype none

// memory word and logging unit geometry
`define AXI_WIDTH                64
`define PACKET_ALIGNMENT         8
`define LOGGING_UNIT_WIDTH       248
`define OFFSET_WIDTH             8

// derived sizes, must stay in step with the four above
`define ALIGN_BITS               3
`define AXI_OFFSET_WIDTH         6
`define ALIGNED_OFFSET_WIDTH     5
`define AXI_ALIGNED_WIDTH        8
`define AXI_ALIGNED_OFFSET_WIDTH 3
`define NUM_AXI                  4

// trace length input and the counters sized from it
`define REPLAY_BITS_WIDTH        32
`define PKT_CNT_WIDTH            29
`define AXI_CNT_WIDTH            26

// elaboration error if any derived size disagrees with the base geometry
`define PARSE_WIDTH_CHECK \
    if (`OFFSET_WIDTH != $clog2(`LOGGING_UNIT_WIDTH + 1)) begin : g_bad_offset_width \
        $error("OFFSET_WIDTH does not match LOGGING_UNIT_WIDTH"); \
    end \
    if (`AXI_OFFSET_WIDTH >= `OFFSET_WIDTH) begin : g_bad_unit_size \
        $error("logging unit must be wider than one memory word"); \
    end \
    if ((`LOGGING_UNIT_WIDTH % `PACKET_ALIGNMENT) != 0 || \
        (`AXI_WIDTH % `PACKET_ALIGNMENT) != 0) begin : g_bad_alignment \
        $error("unit or word width is not a multiple of the alignment"); \
    end \
    if (`ALIGN_BITS != $clog2(`PACKET_ALIGNMENT) || \
        `AXI_OFFSET_WIDTH != $clog2(`AXI_WIDTH) || \
        `AXI_ALIGNED_WIDTH != `AXI_WIDTH / `PACKET_ALIGNMENT || \
        `AXI_ALIGNED_OFFSET_WIDTH != $clog2(`AXI_ALIGNED_WIDTH) || \
        `ALIGNED_OFFSET_WIDTH != $clog2(`LOGGING_UNIT_WIDTH / `PACKET_ALIGNMENT) || \
        `NUM_AXI != (`LOGGING_UNIT_WIDTH - 1) / `AXI_WIDTH + 1) begin : g_bad_derived \
        $error("derived alignment or word counts are inconsistent"); \
    end \
    if (`PKT_CNT_WIDTH != `REPLAY_BITS_WIDTH - `ALIGN_BITS || \
        `AXI_CNT_WIDTH != `REPLAY_BITS_WIDTH - `AXI_OFFSET_WIDTH) begin : g_bad_counters \
        $error("trace counter widths do not follow REPLAY_BITS_WIDTH"); \
    end

`default_nettype wire
`endif

// ==== replay_pkg.sv ====
`include "parse_consts.svh"
`default_nettype none

// shared types of the replay trace parser
package replay_pkg;

    // one memory word as read from the input FIFO
    typedef logic [`AXI_WIDTH-1:0] axi_word_t;
    // one assembled logging unit, length field in the low byte
    typedef logic [`LOGGING_UNIT_WIDTH-1:0] log_unit_t;
    // unit length in bits, and in alignment units
    typedef logic [`OFFSET_WIDTH-1:0] unit_len_t;
    typedef logic [`ALIGNED_OFFSET_WIDTH-1:0] aligned_len_t;
    // byte-aligned position inside the low word
    typedef logic [`AXI_ALIGNED_OFFSET_WIDTH-1:0] aligned_off_t;
    typedef logic [`REPLAY_BITS_WIDTH-1:0] replay_bits_t;
    typedef logic [`PKT_CNT_WIDTH-1:0] pkt_cnt_t;

    typedef enum logic {HI_EMPTY, HI_FULL} hi_state_t;
    typedef enum logic [1:0] {LO_EMPTY, LO_HEADER, LO_BODY} lo_state_t;
    typedef enum logic [1:0] {ASM_WAIT_HEADER, ASM_WAIT_BODY, ASM_DONE} asm_state_t;

endpackage

`default_nettype wire

// ==== replay_hi_stage.sv ====
`include "parse_consts.svh"
`default_nettype none

// high half of the shifting buffer
// holds the word behind the low half and supplies the final zero pad
module replay_hi_stage
    import replay_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         sync_rst_n,
    input  wire axi_word_t    in_data,
    input  wire logic         in_empty,
    input  wire logic         out_almfull,
    input  wire replay_bits_t replay_bits,
    input  wire logic         hi_lo_shift,
    output logic              in_rd_en,
    output logic              hi_full,
    output logic              hi_pad_last,
    output axi_word_t         hi_word
);

    hi_state_t                 hi_state;
    hi_state_t                 hi_state_next;
    logic                      pad_load;
    replay_bits_t              bits_round;
    logic [`AXI_CNT_WIDTH-1:0] axi_total;
    logic [`AXI_CNT_WIDTH-1:0] axi_cnt;

    // read when the half is free or is moving down this cycle
    // almost-full only throttles here, nothing downstream stalls
    assign in_rd_en = !in_empty && !out_almfull && (!hi_full || hi_lo_shift);
    assign hi_full = (hi_state == HI_FULL);

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= HI_EMPTY;
        end else begin
            hi_state <= hi_state_next;
        end
    end

    always_comb begin
        hi_state_next = hi_state;
        case (hi_state)
            HI_EMPTY: begin
                if (in_rd_en) begin
                    hi_state_next = HI_FULL;
                end
            end
            HI_FULL: begin
                // empties only when neither a read nor the pad refills it
                if (hi_lo_shift && !in_rd_en && !hi_pad_last) begin
                    hi_state_next = HI_EMPTY;
                end
            end
            default: begin
                hi_state_next = HI_EMPTY;
            end
        endcase
    end

    // words spanned by the trace, rounded up
    assign bits_round = replay_bits + replay_bits_t'(`AXI_WIDTH - 1);
    assign axi_total = bits_round[`REPLAY_BITS_WIDTH-1:`AXI_OFFSET_WIDTH];

    // last real word is in this half and the pad is still owed
    assign hi_pad_last = hi_full && (axi_cnt != '0) && (axi_cnt == axi_total);
    assign pad_load = hi_lo_shift && hi_pad_last;

    // pad load counts as one more word, so the pad goes in only once
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            axi_cnt <= '0;
        end else if (in_rd_en || pad_load) begin
            axi_cnt <= axi_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_word <= in_data;
        end else if (pad_load) begin
            hi_word <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== replay_lo_stage.sv ====
`include "parse_consts.svh"
`default_nettype none

// low half of the shifting buffer
// walks the units at byte offsets and hands one word window per cycle onward
module replay_lo_stage
    import replay_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         sync_rst_n,
    input  wire replay_bits_t replay_bits,
    input  wire logic         hi_full,
    input  wire axi_word_t    hi_word,
    output logic              hi_lo_shift,
    output logic              lo_out,
    output axi_word_t         lo_out_data,
    output aligned_len_t      lo_remain_len
);

    // offset plus remaining length can exceed either width alone
    localparam int EXH_W = `ALIGNED_OFFSET_WIDTH + `AXI_ALIGNED_OFFSET_WIDTH;

    lo_state_t    lo_state;
    lo_state_t    lo_state_next;
    axi_word_t    lo_word;
    logic [2*`AXI_ALIGNED_WIDTH-1:0][`PACKET_ALIGNMENT-1:0] shift_buf;
    aligned_off_t lo_valid_off;
    aligned_len_t lo_remain_len_q;
    logic         lo_empty;
    logic         lo_exhaust;
    logic         lo_valid_satisfied;
    pkt_cnt_t     pkt_total;
    pkt_cnt_t     pkt_cnt;
    logic         lo_replay_done;

    // window of one word starting at the current aligned offset
    assign shift_buf = {hi_word, lo_word};
    assign lo_out_data = shift_buf[lo_valid_off +: `AXI_ALIGNED_WIDTH];
    assign lo_empty = (lo_state == LO_EMPTY);

    // header state decodes the length field, body state uses what is left
    always_comb begin
        case (lo_state)
            LO_HEADER: lo_remain_len = lo_out_data[`ALIGN_BITS +: `ALIGNED_OFFSET_WIDTH];
            LO_BODY:   lo_remain_len = lo_remain_len_q;
            default:   lo_remain_len = '0;
        endcase
    end

    // everything valid in the low word has gone out with this window
    assign lo_exhaust = (EXH_W'(lo_remain_len) + EXH_W'(lo_valid_off)) >=
                        EXH_W'(`AXI_ALIGNED_WIDTH);
    // the current unit ends within this window
    assign lo_valid_satisfied = (lo_remain_len <= aligned_len_t'(`AXI_ALIGNED_WIDTH));

    assign pkt_total = replay_bits[`REPLAY_BITS_WIDTH-1:`ALIGN_BITS];
    assign lo_replay_done = (pkt_cnt == pkt_total);

    // high half must be full so the window never crosses into stale data
    assign lo_out = hi_full && !lo_empty && !lo_replay_done;
    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= LO_EMPTY;
        end else begin
            lo_state <= lo_state_next;
        end
    end

    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            LO_EMPTY: begin
                if (hi_lo_shift) begin
                    lo_state_next = LO_HEADER;
                end
            end
            LO_HEADER, LO_BODY: begin
                if (hi_lo_shift) begin
                    // unit done means next header, else the body carries on
                    lo_state_next = lo_valid_satisfied ? LO_HEADER : LO_BODY;
                end else if (lo_out) begin
                    // no exhaust, so the unit closed inside the low word
                    lo_state_next = LO_HEADER;
                end
            end
            default: begin
                lo_state_next = LO_EMPTY;
            end
        endcase
    end

    // offset advances by the unit tail, modulo one word
    // a body that continues keeps its offset in the next word
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_valid_off <= '0;
        end else if (lo_empty) begin
            lo_valid_off <= '0;
        end else if (lo_out && lo_valid_satisfied) begin
            lo_valid_off <= lo_valid_off + lo_remain_len[`AXI_ALIGNED_OFFSET_WIDTH-1:0];
        end
    end

    // a full word of the unit went out, keep the rest for the body
    always_ff @(posedge clk) begin
        if (hi_lo_shift && !lo_empty && !lo_valid_satisfied) begin
            lo_remain_len_q <= lo_remain_len - aligned_len_t'(`AXI_ALIGNED_WIDTH);
        end
    end

    // aligned packets passed on so far
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            pkt_cnt <= '0;
        end else if (lo_out) begin
            pkt_cnt <= pkt_cnt + (lo_valid_satisfied ? pkt_cnt_t'(lo_remain_len) :
                                                       pkt_cnt_t'(`AXI_ALIGNED_WIDTH));
        end
    end

    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi_word;
        end
    end

endmodule

`default_nettype wire

// ==== unit_assembler.sv ====
`include "parse_consts.svh"
`default_nettype none

// collects word windows into a logging unit, one write strobe per unit
module unit_assembler
    import replay_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         sync_rst_n,
    input  wire logic         lo_out,
    input  wire axi_word_t    lo_out_data,
    input  wire aligned_len_t lo_remain_len,
    output log_unit_t         out_data,
    output logic              out_wr_en
);

    localparam int CNT_W = $clog2(`NUM_AXI + 1);
    localparam int IDX_W = $clog2(`NUM_AXI);

    asm_state_t asm_state;
    asm_state_t asm_state_next;
    logic       asm_valid;
    axi_word_t  asm_data;
    unit_len_t  asm_len;
    logic [`NUM_AXI-1:0][`AXI_WIDTH-1:0] trace_words;
    logic [`NUM_AXI*`AXI_WIDTH-1:0] trace_flat;
    logic [CNT_W-1:0] trace_axi_cnt;
    unit_len_t  trace_len;
    logic       head_only;
    logic       body_last;

    // register barrier from the shift buffer
    // length is scaled back to bits by appending the alignment zeros
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_valid <= 1'b0;
        end else begin
            asm_valid <= lo_out;
        end
    end

    always_ff @(posedge clk) begin
        asm_data <= lo_out_data;
        asm_len <= {lo_remain_len, {`ALIGN_BITS{1'b0}}};
    end

    // asm_len only means something when the word carries a header
    assign head_only = (asm_len <= unit_len_t'(`AXI_WIDTH));
    // incoming body word covers the rest of the unit
    assign body_last = 32'(trace_len) <= (32'(trace_axi_cnt) + 32'd1) * 32'(`AXI_WIDTH);

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= ASM_WAIT_HEADER;
        end else begin
            asm_state <= asm_state_next;
        end
    end

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            ASM_WAIT_HEADER, ASM_DONE: begin
                // done lasts a single cycle, no back-pressure reaches here
                if (asm_valid) begin
                    asm_state_next = head_only ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HEADER;
                end
            end
            ASM_WAIT_BODY: begin
                if (asm_valid && body_last) begin
                    asm_state_next = ASM_DONE;
                end
            end
            default: begin
                asm_state_next = ASM_WAIT_HEADER;
            end
        endcase
    end

    // word count and unit length, latched from the header word
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            trace_axi_cnt <= '0;
            trace_len <= '0;
        end else if (asm_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                trace_axi_cnt <= trace_axi_cnt + 1'b1;
            end else begin
                trace_axi_cnt <= CNT_W'(1);
                trace_len <= asm_len;
            end
        end
    end

    // header lands in word 0, body words follow by index
    always_ff @(posedge clk) begin
        if (asm_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                trace_words[trace_axi_cnt[IDX_W-1:0]] <= asm_data;
            end else begin
                trace_words[0] <= asm_data;
            end
        end
    end

    // bits above the unit length may be left over from an earlier unit
    assign trace_flat = trace_words;
    assign out_data = trace_flat[`LOGGING_UNIT_WIDTH-1:0];
    assign out_wr_en = (asm_state == ASM_DONE);

endmodule

`default_nettype wire

// ==== replay_trace_parser.sv ====
`include "parse_consts.svh"
`default_nettype none

// replay trace parser top
// memory words in from the input FIFO, logging units out to the output FIFO
module replay_trace_parser
    import replay_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         sync_rst_n,
    input  wire axi_word_t    in_data,
    input  wire logic         in_empty,
    output logic              in_rd_en,
    output log_unit_t         out_data,
    output logic              out_wr_en,
    input  wire logic         out_almfull,
    input  wire replay_bits_t replay_bits
);

    // high half towards low half
    logic         hi_full;
    axi_word_t    hi_word;
    // low half back to high half
    logic         hi_lo_shift;
    // low half towards the assembler
    logic         lo_out;
    axi_word_t    lo_out_data;
    aligned_len_t lo_remain_len;

    `PARSE_WIDTH_CHECK

    replay_hi_stage u_hi_stage (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .in_rd_en    (in_rd_en),
        .hi_full     (hi_full),
        .hi_pad_last (),
        .hi_word     (hi_word)
    );

    replay_lo_stage u_lo_stage (
        .clk           (clk),
        .sync_rst_n    (sync_rst_n),
        .replay_bits   (replay_bits),
        .hi_full       (hi_full),
        .hi_word       (hi_word),
        .hi_lo_shift   (hi_lo_shift),
        .lo_out        (lo_out),
        .lo_out_data   (lo_out_data),
        .lo_remain_len (lo_remain_len)
    );

    unit_assembler u_assembler (
        .clk           (clk),
        .sync_rst_n    (sync_rst_n),
        .lo_out        (lo_out),
        .lo_out_data   (lo_out_data),
        .lo_remain_len (lo_remain_len),
        .out_data      (out_data),
        .out_wr_en     (out_wr_en)
    );

endmodule

`default_nettype wire

// ==== replay_checker.sv ====
`include "parse_consts.svh"
`default_nettype none

// port-level assertions on the parser top
module replay_checker
    import replay_pkg::*;
(
    input wire logic      clk,
    input wire logic      sync_rst_n,
    input wire logic      in_empty,
    input wire logic      in_rd_en,
    input wire log_unit_t out_data,
    input wire logic      out_wr_en
);
    timeunit 1ns;
    timeprecision 1ps;

    // never pop an empty input FIFO
    a_no_read_empty: assert property (@(posedge clk) disable iff (!sync_rst_n)
        in_empty |-> !in_rd_en)
        else $error("read strobe while input FIFO empty");

    // length field of every written unit is sane
    a_len_field: assert property (@(posedge clk) disable iff (!sync_rst_n)
        out_wr_en |-> (out_data[`OFFSET_WIDTH-1:0] != '0 &&
                       out_data[`OFFSET_WIDTH-1:0] <= `LOGGING_UNIT_WIDTH &&
                       out_data[`ALIGN_BITS-1:0] == '0))
        else $error("bad length field on write");

    // synchronous reset clears the write strobe by the next edge
    a_reset_quiet: assert property (@(posedge clk) !sync_rst_n |=> !out_wr_en)
        else $error("write strobe during reset");

endmodule

bind replay_trace_parser replay_checker u_checker (.*);

`default_nettype wire

// ==== tb_replay_trace_parser.sv ====
`include "parse_consts.svh"
`default_nettype none

// testbench for the replay trace parser
// words and expected units come from replay_trace.txt
module tb_replay_trace_parser
    import replay_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SINK_DEPTH = 6;
    localparam int WAIT_LIMIT = 2000;

    logic         clk = 1'b0;
    logic         sync_rst_n;
    axi_word_t    in_data = '0;
    logic         in_empty = 1'b1;
    logic         in_rd_en;
    log_unit_t    out_data;
    logic         out_wr_en;
    logic         out_almfull = 1'b0;
    replay_bits_t replay_bits;

    // input FIFO model, expected units, output sink
    axi_word_t    in_q[$];
    axi_word_t    words[$];
    unit_len_t    exp_len[$];
    log_unit_t    exp_data[$];
    log_unit_t    out_q[$];

    int           seed = 32'h1ef9b174;
    int           errors = 0;
    int           tests_run = 0;
    int           tests_bad = 0;
    int           rcv_cnt = 0;
    int           wr_cnt = 0;
    int           max_depth = 0;
    bit           aborted = 1'b0;

    replay_trace_parser UUT (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_data    (out_data),
        .out_wr_en   (out_wr_en),
        .out_almfull (out_almfull),
        .replay_bits (replay_bits)
    );

    always #10 clk = ~clk;

    task automatic check_len(input int idx, input unit_len_t got, input unit_len_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: unit %0d length %0d, expected %0d", $time, idx, got, exp);
            errors++;
        end
    endtask

    // only bits below the expected length carry meaning
    task automatic check_unit(input int idx, input log_unit_t got, input log_unit_t exp,
                              input unit_len_t len);
        bit bad;
        bad = 1'b0;
        for (int b = 0; b < `LOGGING_UNIT_WIDTH; b++) begin
            if (b < int'(len) && got[b] !== exp[b]) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("Fail at %0t: unit %0d data %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic wait_units(input int n, input string what);
        int cyc;
        cyc = 0;
        while (rcv_cnt < n && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        if (rcv_cnt < n) begin
            $display("timeout: gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors != err_before || aborted) begin
            tests_bad++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    len_i;
        string line;
        axi_word_t w;
        log_unit_t d;
        fd = $fopen("replay_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open replay_trace.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line.getc(0) == "B") begin
                    void'($sscanf(line, "B %h", replay_bits));
                end else if (line.len() > 2 && line.getc(0) == "W") begin
                    void'($sscanf(line, "W %h", w));
                    words.push_back(w);
                end else if (line.len() > 2 && line.getc(0) == "U") begin
                    void'($sscanf(line, "U %d %h", len_i, d));
                    exp_len.push_back(unit_len_t'(len_i));
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    // sample at the edge, update the FIFO models 2 ns later
    always @(posedge clk) begin
        logic      rd_s;
        logic      wr_s;
        log_unit_t d_s;
        log_unit_t u;
        rd_s = in_rd_en;
        wr_s = out_wr_en;
        d_s = out_data;
        #2;
        if (rd_s && in_q.size() > 0) begin
            in_q.delete(0);
        end
        if (wr_s) begin
            out_q.push_back(d_s);
            wr_cnt++;
        end
        if (out_q.size() > max_depth) begin
            max_depth = out_q.size();
        end
        // random drain enable, roughly three cycles in four
        if (out_q.size() > 0 && ($random(seed) & 3) != 0) begin
            u = out_q.pop_front();
            if (rcv_cnt >= exp_len.size()) begin
                $display("unit %0d arrived but the trace expects only %0d units",
                         rcv_cnt, exp_len.size());
                errors++;
            end else begin
                check_len(rcv_cnt, u[`OFFSET_WIDTH-1:0], exp_len[rcv_cnt]);
                check_unit(rcv_cnt, u, exp_data[rcv_cnt], exp_len[rcv_cnt]);
            end
            rcv_cnt++;
        end
        in_empty = (in_q.size() == 0);
        in_data = (in_q.size() > 0) ? in_q[0] : '0;
        out_almfull = (out_q.size() >= SINK_DEPTH);
    end

    initial begin
        int e0;
        sync_rst_n = 1'b0;
        replay_bits = '0;
        read_trace();

        // reset, then a few idle cycles with the input FIFO still empty
        // strobes are looked at just after the edge, once the reset has taken hold
        e0 = errors;
        repeat (10) begin
            @(posedge clk);
            #1;
            if (in_rd_en !== 1'b0 || out_wr_en !== 1'b0) begin
                $display("Fail at %0t: strobe active during reset", $time);
                errors++;
            end
        end
        #1 sync_rst_n = 1'b1;
        repeat (5) begin
            @(posedge clk);
            if (in_rd_en !== 1'b0 || out_wr_en !== 1'b0) begin
                $display("Fail at %0t: strobe active with the input empty", $time);
                errors++;
            end
        end
        report("reset", e0);

        foreach (words[i]) begin
            in_q.push_back(words[i]);
        end

        // first four units fit in one word each
        e0 = errors;
        if (!aborted) wait_units(4, "the single-word units");
        report("short units", e0);

        e0 = errors;
        if (!aborted) wait_units(8, "the multi-word units");
        report("long units", e0);

        e0 = errors;
        if (!aborted) wait_units(exp_len.size(), "the remaining units");
        if (max_depth > SINK_DEPTH + 2) begin
            $display("output queue held %0d units, more than %0d", max_depth, SINK_DEPTH + 2);
            errors++;
        end
        report("random drain", e0);

        // nothing more may come out after the last unit
        e0 = errors;
        if (!aborted) begin
            repeat (200) @(posedge clk);
            if (wr_cnt != exp_len.size() || rcv_cnt != exp_len.size()) begin
                $display("saw %0d writes and %0d drained units, expected %0d",
                         wr_cnt, rcv_cnt, exp_len.size());
                errors++;
            end
        end
        report("end of trace", e0);

        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_bad, errors);
        if (errors == 0 && !aborted) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== replay_trace.txt ====
# B <replay_bits hex> | W <input word hex> | U <unit length in bits, decimal> <unit data hex>
# words are listed in FIFO order, units in expected output order
B 3b0
W 0706050403020140
W 2423222128121118
W 464544434241a008
W 4e4d4c4b4a494847
W 5251f8434241404f
W 5a59585756555453
W 5251505f5e5d5c5b
W 5a59585756555453
W 636261605e5d5c5b
W 6b6a696867666564
W 7776757473727148
W 9493929180811078
W 9c9b9a9998979695
W a4a3a2a1389f9e9d
W 0000b3b2b120a6a5
U 64 0706050403020140
U 24 121118
U 40 2423222128
U 8 08
U 160 434241404f4e4d4c4b4a494847464544434241a0
U 248 5e5d5c5b5a595857565554535251505f5e5d5c5b5a595857565554535251f8
U 96 6b6a69686766656463626160
U 72 787776757473727148
U 16 8110
U 128 9f9e9d9c9b9a99989796959493929180
U 56 a6a5a4a3a2a138
U 32 b3b2b120

// ==== sources.f ====
+incdir+.
replay_pkg.sv
replay_hi_stage.sv
replay_lo_stage.sv
unit_assembler.sv
replay_trace_parser.sv
replay_checker.sv
tb_replay_trace_parser.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log"
	@echo "  clean  remove build output and logs"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_replay_trace_parser -f sources.f
	./obj_dir/Vtb_replay_trace_parser > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" sim.log || \
	   ! grep -q "=== PASS ===" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
